/* rtl/mips_pkg.sv */
// shared widths, instruction encodings and decoder control types; imported by every core file
package mips_pkg;

   typedef logic [31:0] word_t;       // data, pc or register value
   typedef logic [29:0] word_addr_t;  // word address on memory ports
   typedef logic [4:0]  reg_addr_t;
   typedef logic [3:0]  byte_en_t;    // store byte mask
   typedef logic [15:0] imm16_t;

   // primary opcodes
   localparam logic [5:0] op_special = 6'h00;
   localparam logic [5:0] op_j       = 6'h02;
   localparam logic [5:0] op_jal     = 6'h03;
   localparam logic [5:0] op_beq     = 6'h04;
   localparam logic [5:0] op_bne     = 6'h05;
   localparam logic [5:0] op_addi    = 6'h08;
   localparam logic [5:0] op_addiu   = 6'h09;
   localparam logic [5:0] op_slti    = 6'h0a;
   localparam logic [5:0] op_andi    = 6'h0c;
   localparam logic [5:0] op_ori     = 6'h0d;
   localparam logic [5:0] op_xori    = 6'h0e;
   localparam logic [5:0] op_lui     = 6'h0f;
   localparam logic [5:0] op_lb      = 6'h20;
   localparam logic [5:0] op_lh      = 6'h21;
   localparam logic [5:0] op_lw      = 6'h23;
   localparam logic [5:0] op_lbu     = 6'h24;
   localparam logic [5:0] op_lhu     = 6'h25;
   localparam logic [5:0] op_sw      = 6'h2b;

   // funct field of special opcode
   localparam logic [5:0] fn_sll     = 6'h00;
   localparam logic [5:0] fn_srl     = 6'h02;
   localparam logic [5:0] fn_sra     = 6'h03;
   localparam logic [5:0] fn_sllv    = 6'h04;
   localparam logic [5:0] fn_srlv    = 6'h06;
   localparam logic [5:0] fn_srav    = 6'h07;
   localparam logic [5:0] fn_jr      = 6'h08;
   localparam logic [5:0] fn_jalr    = 6'h09;
   localparam logic [5:0] fn_syscall = 6'h0c;
   localparam logic [5:0] fn_add     = 6'h20;
   localparam logic [5:0] fn_addu    = 6'h21;
   localparam logic [5:0] fn_sub     = 6'h22;
   localparam logic [5:0] fn_subu    = 6'h23;
   localparam logic [5:0] fn_and     = 6'h24;
   localparam logic [5:0] fn_or      = 6'h25;
   localparam logic [5:0] fn_xor     = 6'h26;
   localparam logic [5:0] fn_nor     = 6'h27;
   localparam logic [5:0] fn_slt     = 6'h2a;

   localparam reg_addr_t reg_v0        = 5'd2;   // syscall argument
   localparam reg_addr_t reg_ra        = 5'd31;  // link register for jal
   localparam word_t     sys_exit_code = 32'd10; // $v0 value that halts

   // shifts cover both shamt and variable forms, picked by shift_sa
   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
      alu_slt, alu_sll, alu_srl, alu_sra
   } alu_op_e;

   typedef enum logic [2:0] {
      ld_lui, ld_lb, ld_lh, ld_lw, ld_lbu, ld_lhu
   } load_sel_e;

   typedef enum logic [1:0] {
      pc_seq, pc_branch, pc_reg, pc_jump
   } pc_sel_e;

   typedef enum logic [1:0] {
      wb_alu, wb_load, wb_link
   } wb_sel_e;

   typedef struct packed {
      logic      reg_we;   // write dst
      reg_addr_t dst;
      alu_op_e   alu_op;
      logic      src_imm;  // immediate as second operand
      logic      shift_sa; // shamt field as shift amount
      logic      mem_we;   // sw
      load_sel_e load_sel;
      wb_sel_e   wb_sel;
      pc_sel_e   pc_sel;
      logic      br_ne;    // bne, else beq
      logic      sys;      // syscall
      logic      ri;       // reserved instruction
   } ctrl_t;

endpackage

/* rtl/pc_unit.sv */
// program counter pair with one branch delay slot, next-pc select and halt state
`timescale 1ns/100ps

module pc_unit #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic            clk,
   input  logic            rst_b,
   input  mips_pkg::ctrl_t ctrl,
   input  mips_pkg::word_t rs_data,
   input  mips_pkg::word_t rt_data,
   input  mips_pkg::word_t imm,      // sign-extended offset
   input  logic [25:0]     target,   // jump field
   output mips_pkg::word_t pc,
   output mips_pkg::word_t link,
   output logic            halt_req, // this cycle's inst halts
   output logic            halted
);
   import mips_pkg::*;

   word_t npc;          // delay slot pc
   word_t new_npc;
   word_t seq_pc;
   word_t br_target;
   word_t j_target;
   logic  br_taken;

   assign seq_pc    = npc + 32'd4;
   assign br_target = pc + 32'd4 + {imm[29:0], 2'b00};
   assign j_target  = {pc[31:28], target, 2'b00};
   assign br_taken  = (rs_data == rt_data) ^ ctrl.br_ne; // beq or bne
   assign link      = pc + 32'd8; // skips delay slot

   // rs read port carries $v0 for syscall
   assign halt_req = ctrl.ri | (ctrl.sys & (rs_data == sys_exit_code));

   always_comb begin
      case (ctrl.pc_sel)
         pc_branch: new_npc = br_taken ? br_target : seq_pc;
         pc_reg:    new_npc = rs_data;   // jr, jalr
         pc_jump:   new_npc = j_target;  // j, jal
         default:   new_npc = seq_pc;
      endcase
   end

   // new target lands in npc, so the slot after a jump still runs
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc  <= text_start;
         npc <= text_start + 32'd4;
      end else if (!halt_req && !halted) begin
         pc  <= npc;
         npc <= new_npc;
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (halt_req) begin
         halted <= 1'b1; // sticky until reset
      end
   end

endmodule

/* rtl/mips_decode.sv */
// instruction decoder; slices fields, builds the control struct and the extended immediate
`timescale 1ns/100ps

module mips_decode (
   input  mips_pkg::word_t     inst,
   output mips_pkg::ctrl_t     ctrl,
   output mips_pkg::word_t     imm,
   output mips_pkg::reg_addr_t rs_addr,
   output mips_pkg::reg_addr_t rt_addr
);
   import mips_pkg::*;

   logic [5:0] opcode;
   logic [5:0] funct;
   reg_addr_t  rs;
   reg_addr_t  rt;
   reg_addr_t  rd;
   imm16_t     imm16;
   logic       sign_ext; // else zero extend

   assign opcode = inst[31:26];
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   assign funct  = inst[5:0];
   assign imm16  = inst[15:0];

   // syscall reads $v0 for the halt check
   assign rs_addr = ctrl.sys ? reg_v0 : rs;
   assign rt_addr = rt;

   // shamt stays at imm[10:6] either way
   assign imm = sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};

   always_comb begin
      ctrl          = '0;
      ctrl.dst      = rt;      // i-type default
      ctrl.alu_op   = alu_add;
      ctrl.load_sel = ld_lw;
      ctrl.wb_sel   = wb_alu;
      ctrl.pc_sel   = pc_seq;
      sign_ext      = 1'b1;
      case (opcode)
         op_special: begin
            ctrl.dst    = rd;
            ctrl.reg_we = 1'b1;
            case (funct)
               fn_add, fn_addu: ctrl.alu_op = alu_add; // no overflow trap
               fn_sub, fn_subu: ctrl.alu_op = alu_sub;
               fn_and:  ctrl.alu_op = alu_and;
               fn_or:   ctrl.alu_op = alu_or;
               fn_xor:  ctrl.alu_op = alu_xor;
               fn_nor:  ctrl.alu_op = alu_nor;
               fn_slt:  ctrl.alu_op = alu_slt;
               fn_sll:  ctrl.alu_op = alu_sll;
               fn_srl:  ctrl.alu_op = alu_srl;
               fn_sra:  ctrl.alu_op = alu_sra;
               fn_sllv: ctrl.alu_op = alu_sll;  // amount from rs
               fn_srlv: ctrl.alu_op = alu_srl;
               fn_srav: ctrl.alu_op = alu_sra;
               fn_jr: begin
                  ctrl.reg_we = 1'b0;
                  ctrl.pc_sel = pc_reg;
               end
               fn_jalr: begin
                  ctrl.pc_sel = pc_reg;
                  ctrl.wb_sel = wb_link; // link into rd
               end
               fn_syscall: begin
                  ctrl.reg_we = 1'b0;
                  ctrl.sys    = 1'b1;
               end
               default: begin
                  ctrl.reg_we = 1'b0;
                  ctrl.ri     = 1'b1;
               end
            endcase
            // fixed shifts take the sa field
            ctrl.shift_sa = (funct == fn_sll) | (funct == fn_srl) | (funct == fn_sra);
         end
         op_addi, op_addiu: {ctrl.reg_we, ctrl.src_imm} = 2'b11;
         op_slti: begin
            {ctrl.reg_we, ctrl.src_imm} = 2'b11;
            ctrl.alu_op = alu_slt;
         end
         op_andi, op_ori, op_xori: begin
            {ctrl.reg_we, ctrl.src_imm} = 2'b11;
            sign_ext = 1'b0; // logical immediates zero extend
            ctrl.alu_op = (opcode == op_andi) ? alu_and :
                          (opcode == op_ori)  ? alu_or  : alu_xor;
         end
         op_lui: begin
            ctrl.reg_we   = 1'b1;
            ctrl.load_sel = ld_lui; // built in load unit
            ctrl.wb_sel   = wb_load;
         end
         op_lb, op_lh, op_lw, op_lbu, op_lhu: begin
            {ctrl.reg_we, ctrl.src_imm} = 2'b11; // base + offset
            ctrl.wb_sel = wb_load;
            case (opcode)
               op_lb:   ctrl.load_sel = ld_lb;
               op_lh:   ctrl.load_sel = ld_lh;
               op_lbu:  ctrl.load_sel = ld_lbu;
               op_lhu:  ctrl.load_sel = ld_lhu;
               default: ctrl.load_sel = ld_lw;
            endcase
         end
         op_sw: {ctrl.mem_we, ctrl.src_imm} = 2'b11;
         op_beq, op_bne: begin
            ctrl.pc_sel = pc_branch;
            ctrl.br_ne  = (opcode == op_bne);
         end
         op_j:   ctrl.pc_sel = pc_jump;
         op_jal: begin
            ctrl.pc_sel = pc_jump;
            ctrl.reg_we = 1'b1;
            ctrl.dst    = reg_ra;
            ctrl.wb_sel = wb_link;
         end
         default: ctrl.ri = 1'b1; // unknown opcode halts
      endcase
   end

endmodule

/* rtl/regfile.sv */
// 32 x 32-bit register file, two combinational read ports and one clocked write port
`timescale 1ns/100ps

module regfile (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::reg_addr_t rs_addr,
   input  mips_pkg::reg_addr_t rt_addr,
   input  mips_pkg::reg_addr_t wr_addr,
   input  mips_pkg::word_t     wr_data,
   input  logic                we,
   output mips_pkg::word_t     rs_data,
   output mips_pkg::word_t     rt_data
);
   import mips_pkg::*;

   word_t regs [32];

   // $zero is cleared at reset and never written
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wr_addr != 5'd0)) begin
         regs[wr_addr] <= wr_data;
      end
   end

endmodule

/* rtl/mips_alu.sv */
// alu with operand select; add, sub, logic, signed compare and shifts
`timescale 1ns/100ps

module mips_alu (
   input  mips_pkg::ctrl_t ctrl,
   input  mips_pkg::word_t rs_data,
   input  mips_pkg::word_t rt_data,
   input  mips_pkg::word_t imm,
   output mips_pkg::word_t alu_out
);
   import mips_pkg::*;

   word_t      op_b;  // second operand
   logic [4:0] shamt;

   assign op_b  = ctrl.src_imm ? imm : rt_data;
   assign shamt = ctrl.shift_sa ? imm[10:6] : rs_data[4:0]; // sa field or rs

   always_comb begin
      case (ctrl.alu_op)
         alu_add: alu_out = rs_data + op_b;
         alu_sub: alu_out = rs_data - op_b;
         alu_and: alu_out = rs_data & op_b;
         alu_or:  alu_out = rs_data | op_b;
         alu_xor: alu_out = rs_data ^ op_b;
         alu_nor: alu_out = ~(rs_data | op_b);
         alu_slt: begin
            // signed compare, slt and slti
            alu_out = ($signed(rs_data) < $signed(op_b)) ? 32'd1 : 32'd0;
         end
         alu_sll: alu_out = rt_data << shamt;
         alu_srl: alu_out = rt_data >> shamt;
         alu_sra: alu_out = word_t'($signed(rt_data) >>> shamt); // keeps sign
         default: alu_out = '0;
      endcase
   end

endmodule

/* rtl/load_unit.sv */
// load extension, lui placement and write-back select for the register file
`timescale 1ns/100ps

module load_unit (
   input  mips_pkg::ctrl_t ctrl,
   input  mips_pkg::word_t imm,
   input  mips_pkg::word_t mem_data_out,
   input  mips_pkg::word_t alu_out,
   input  mips_pkg::word_t link,    // pc + 8
   output mips_pkg::word_t wb_data
);
   import mips_pkg::*;

   word_t ld_data;

   // sub-word loads use the low bits of the word, no byte lanes
   always_comb begin
      case (ctrl.load_sel)
         ld_lui:  ld_data = {imm[15:0], 16'h0000};
         ld_lb:   ld_data = {{24{mem_data_out[7]}}, mem_data_out[7:0]};
         ld_lh:   ld_data = {{16{mem_data_out[15]}}, mem_data_out[15:0]};
         ld_lbu:  ld_data = {24'h000000, mem_data_out[7:0]};
         ld_lhu:  ld_data = {16'h0000, mem_data_out[15:0]};
         default: ld_data = mem_data_out; // lw
      endcase
   end

   always_comb begin
      case (ctrl.wb_sel)
         wb_load: wb_data = ld_data;
         wb_link: wb_data = link;  // jal, jalr
         default: wb_data = alu_out;
      endcase
   end

endmodule

/* rtl/mips_core.sv */
// single-cycle mips core top; connect instruction and data memory that answer in the same cycle
`timescale 1ns/100ps

module mips_core #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000 // reset pc
) (
   input  logic                 clk,
   input  logic                 rst_b,
   output mips_pkg::word_addr_t inst_addr,    // fetch word address
   input  mips_pkg::word_t      inst,
   output mips_pkg::word_addr_t mem_addr,
   output mips_pkg::word_t      mem_data_in,  // store data
   input  mips_pkg::word_t      mem_data_out, // load data
   output mips_pkg::byte_en_t   mem_write_en,
   output logic                 halted
);
   import mips_pkg::*;

   ctrl_t     ctrl;
   word_t     imm;         // extended immediate
   reg_addr_t rs_addr;
   reg_addr_t rt_addr;
   word_t     rs_data;
   word_t     rt_data;
   word_t     alu_out;
   word_t     wb_data;
   word_t     pc;
   word_t     link;        // pc + 8
   logic      halt_req;
   logic      rf_we;

   assign inst_addr    = pc[31:2];
   assign mem_addr     = alu_out[31:2];
   assign mem_data_in  = rt_data;
   assign mem_write_en = {4{ctrl.mem_we & ~halt_req & ~halted}}; // sw only, full word
   assign rf_we        = ctrl.reg_we & ~halt_req & ~halted;      // halting inst writes nothing

   pc_unit #(.text_start(text_start)) i_pc_unit (
      .clk, .rst_b, .ctrl, .rs_data, .rt_data, .imm,
      .target   (inst[25:0]),
      .pc, .link, .halt_req, .halted
   );

   mips_decode i_mips_decode (
      .inst, .ctrl, .imm, .rs_addr, .rt_addr
   );

   regfile i_regfile (
      .clk, .rst_b, .rs_addr, .rt_addr,
      .wr_addr (ctrl.dst),
      .wr_data (wb_data),
      .we      (rf_we),
      .rs_data, .rt_data
   );

   mips_alu i_mips_alu (
      .ctrl, .rs_data, .rt_data, .imm, .alu_out
   );

   load_unit i_load_unit (
      .ctrl, .imm, .mem_data_out, .alu_out, .link, .wb_data
   );

endmodule

/* dv/mips_core_assert.sv */
// concurrent checks on the core's store mask and halt behavior, bound into every core instance
`timescale 1ns/100ps

module mips_core_assert (
   input logic                 clk,
   input logic                 rst_b,
   input mips_pkg::word_addr_t inst_addr,
   input mips_pkg::byte_en_t   mem_write_en,
   input logic                 halted
);

   // sw is the only store
   full_word_store: assert property (@(posedge clk) disable iff (!rst_b)
      mem_write_en == 4'h0 || mem_write_en == 4'hf)
      else $error("partial store mask %h", mem_write_en);

   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> halted && $stable(inst_addr))
      else $error("halted dropped or fetch address moved while halted");

   halt_no_store: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> mem_write_en == 4'h0)
      else $error("store issued while halted");

endmodule

bind mips_core mips_core_assert i_mips_core_assert (
   .clk, .rst_b, .inst_addr, .mem_write_en, .halted
);

/* dv/mips_ref.svh */
// instruction-set reference model, included inside the testbench module and stepped once per cycle
`ifndef MIPS_REF_SVH
`define MIPS_REF_SVH

// port values expected during one instruction's cycle
typedef struct packed {
   word_addr_t inst_addr;
   logic       halted;
   byte_en_t   st_en;    // store mask, zero when no store
   word_addr_t st_addr;
   word_t      st_data;
} expect_t;

word_t ref_regs [32];
word_t ref_imem [256];
word_t ref_dmem [256];
word_t ref_pc;
word_t ref_npc;     // delay slot pc
logic  ref_halted;

function automatic void ref_reset(input word_t start);
   foreach (ref_regs[i]) ref_regs[i] = '0;
   ref_pc     = start;
   ref_npc    = start + 32'd4;
   ref_halted = 1'b0;
endfunction

// executes the instruction at ref_pc and returns what the ports show meanwhile
function automatic expect_t ref_step();
   expect_t    e;
   word_t      ins, a, b, se, ea, ld, r, nxt;
   logic [4:0] sa;
   reg_addr_t  d;
   logic       wr;
   logic       stop;
   e           = '0;
   e.inst_addr = ref_pc[31:2];
   e.halted    = ref_halted;
   if (ref_halted) return e;   // frozen, nothing happens
   ins  = ref_imem[ref_pc[9:2]];
   a    = ref_regs[ins[25:21]];
   b    = ref_regs[ins[20:16]];
   se   = {{16{ins[15]}}, ins[15:0]};
   ea   = a + se;              // load and store address
   ld   = ref_dmem[ea[9:2]];
   sa   = ins[10:6];
   d    = ins[20:16];          // rt unless r-type or jal
   wr   = 1'b1;
   stop = 1'b0;
   r    = '0;
   nxt  = ref_npc + 32'd4;
   case (ins[31:26])
      op_special: begin
         d = ins[15:11];
         case (ins[5:0])
            fn_add, fn_addu: r = a + b;
            fn_sub, fn_subu: r = a - b;
            fn_and:  r = a & b;
            fn_or:   r = a | b;
            fn_xor:  r = a ^ b;
            fn_nor:  r = ~(a | b);
            fn_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fn_sll:  r = b << sa;
            fn_srl:  r = b >> sa;
            fn_sra:  r = $signed(b) >>> sa;
            fn_sllv: r = b << a[4:0];
            fn_srlv: r = b >> a[4:0];
            fn_srav: r = $signed(b) >>> a[4:0];
            fn_jr:   {wr, nxt} = {1'b0, a};
            fn_jalr: {r, nxt} = {ref_pc + 32'd8, a};      // link past the slot
            fn_syscall: {wr, stop} = {1'b0, ref_regs[reg_v0] == sys_exit_code};
            default: stop = 1'b1;                        // undefined funct
         endcase
      end
      op_addi, op_addiu: r = a + se;
      op_slti: r = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
      op_andi: r = a & {16'h0, ins[15:0]};
      op_ori:  r = a | {16'h0, ins[15:0]};
      op_xori: r = a ^ {16'h0, ins[15:0]};
      op_lui:  r = {ins[15:0], 16'h0};
      op_lw:   r = ld;
      op_lb:   r = {{24{ld[7]}}, ld[7:0]};
      op_lbu:  r = {24'h0, ld[7:0]};
      op_lh:   r = {{16{ld[15]}}, ld[15:0]};
      op_lhu:  r = {16'h0, ld[15:0]};
      op_sw:   {wr, e.st_en, e.st_addr, e.st_data} = {1'b0, 4'hf, ea[31:2], b};
      op_beq, op_bne: begin
         wr = 1'b0;
         if ((a == b) != (ins[31:26] == op_bne)) nxt = ref_pc + 32'd4 + (se << 2);
      end
      op_j:    {wr, nxt} = {1'b0, ref_pc[31:28], ins[25:0], 2'b00};
      op_jal:  {d, r, nxt} = {reg_ra, ref_pc + 32'd8, ref_pc[31:28], ins[25:0], 2'b00};
      default: stop = 1'b1;   // undefined opcode
   endcase
   if (stop) begin
      ref_halted = 1'b1;      // no write, pc pair stays
      return e;
   end
   if (e.st_en != '0) ref_dmem[ea[9:2]] = b;
   if (wr && d != 5'd0) ref_regs[d] = r;
   ref_pc  = ref_npc;
   ref_npc = nxt;
   return e;
endfunction

`endif

/* dv/tb_mips_core.sv */
// testbench for the single-cycle core; loads small programs and checks every cycle against a reference
`timescale 1ns/100ps

module tb_mips_core;
   import mips_pkg::*;

   localparam word_t text_start = 32'h0040_0000;
   // ops run by the alu and load programs, six bits each
   localparam logic [89:0] r_ops = {fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor,
      fn_nor, fn_slt, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
   localparam logic [35:0] i_ops  = {op_addi, op_addiu, op_andi, op_ori, op_xori, op_slti};
   localparam logic [29:0] ld_ops = {op_lw, op_lb, op_lbu, op_lh, op_lhu};

   `include "mips_ref.svh"

   logic       clk;
   logic       rst_b;
   word_addr_t inst_addr;
   word_t      inst;
   word_addr_t mem_addr;
   word_t      mem_data_in;
   word_t      mem_data_out;
   byte_en_t   mem_write_en;
   logic       halted;
   word_t      imem [256];
   word_t      dmem [256];
   int         seed;
   int         errors;
   int         n;          // next program slot
   int         st_off;     // next store byte address
   string      test_name;

   mips_core #(.text_start(text_start)) i_mips_core (.*);

   // both memories answer in the same cycle
   assign inst         = imem[inst_addr[7:0]];
   assign mem_data_out = dmem[mem_addr[7:0]];

   always @(posedge clk) begin
      if (mem_write_en != '0) dmem[mem_addr[7:0]] <= mem_data_in;
   end

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // pre-edge port values against one reference step
   always @(posedge clk) begin : compare
      expect_t e;
      if (rst_b) begin
         e = ref_step();
         check_addr("inst_addr", e.inst_addr, inst_addr);
         check_bit("halted", e.halted, halted);
         check_en("mem_write_en", e.st_en, mem_write_en);
         if (e.st_en != '0) begin
            check_addr("mem_addr", e.st_addr, mem_addr);
            check_word("mem_data_in", e.st_data, mem_data_in);
         end
      end
   end

   task automatic report_mismatch(input string what, input string exp_s, input string act_s);
      errors++;
      $display("Fail %s %s: expected %s, actual %s", test_name, what, exp_s, act_s);
      $display("Finished with errors");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic check_addr(input string what, input word_addr_t exp, input word_addr_t act);
      if (exp !== act) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_word(input string what, input word_t exp, input word_t act);
      if (exp !== act) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_en(input string what, input byte_en_t exp, input byte_en_t act);
      if (exp !== act) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (exp !== act) report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
   endtask

   function automatic word_t rtype(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                   reg_addr_t rd, logic [4:0] sa);
      return {op_special, rs, rt, rd, sa, fn};
   endfunction

   function automatic word_t itype(logic [5:0] op, reg_addr_t rs, reg_addr_t rt, imm16_t imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t jtype(logic [5:0] op, int slot);
      word_t a;
      a = text_start + slot * 4;   // program slot to byte address
      return {op, a[27:2]};
   endfunction

   task automatic put(input word_t w);
      imem[n]     = w;
      ref_imem[n] = w;
      n++;
   endtask

   task automatic poke(input int idx, input word_t w);
      dmem[idx]     = w;
      ref_dmem[idx] = w;
   endtask

   task automatic store(input reg_addr_t r);
      put(itype(op_sw, 5'd0, r, imm16_t'(st_off)));
      st_off += 4;
   endtask

   task automatic load_const(input reg_addr_t r, input word_t v);
      put(itype(op_lui, 5'd0, r, v[31:16]));
      put(itype(op_ori, r, r, v[15:0]));
   endtask

   task automatic halt_syscall();
      put(itype(op_ori, 5'd0, reg_v0, imm16_t'(sys_exit_code)));
      put(rtype(fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
   endtask

   // branch, slot store, then a store that a taken branch skips
   task automatic branch_case(input word_t w, input reg_addr_t slot_reg);
      put(w);
      store(slot_reg);
      store(5'd10);
   endtask

   task automatic fill_memories();
      for (int i = 0; i < 256; i++) begin
         imem[i]     = {6'h3f, 18'h0, i[7:0]};   // undefined opcode halts a runaway
         ref_imem[i] = imem[i];
         dmem[i]     = {8'hd0, 16'h0, i[7:0]};
         ref_dmem[i] = dmem[i];
      end
   endtask

   task automatic start_program(input string name);
      @(negedge clk);
      rst_b     = 1'b0;
      test_name = name;
      n         = 0;
      st_off    = 32'h100;
      fill_memories();
      ref_reset(text_start);
   endtask

   task automatic wait_halted(input int limit);
      int cycles;
      cycles = 0;
      while (!halted && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("%s: core did not halt within %0d cycles", test_name, limit);
         $display("Finished with errors");
         $fatal(1, "halt timeout");
      end
   endtask

   task automatic run_program();
      repeat (10) @(negedge clk);
      check_addr("reset inst_addr", text_start[31:2], inst_addr);
      check_bit("reset halted", 1'b0, halted);
      rst_b = 1'b1;
      wait_halted(500);
      repeat (4) @(negedge clk);   // frozen state still compared each edge
      foreach (ref_regs[i]) begin
         check_word($sformatf("reg %0d", i), ref_regs[i], i_mips_core.i_regfile.regs[i]);
      end
   endtask

   initial begin : main
      word_t x;
      seed   = 32'h9fa7;
      errors = 0;
      rst_b  = 1'b0;
      n      = 0;
      fill_memories();
      ref_reset(text_start);
      start_program("alu");
      load_const(5'd8, $random(seed));
      load_const(5'd9, $random(seed));
      for (int k = 0; k < 15; k++) begin
         put(rtype(r_ops[k*6 +: 6], 5'd8, 5'd9, 5'd11, 5'($random(seed))));
         store(5'd11);
      end
      for (int k = 0; k < 6; k++) begin
         put(itype(i_ops[k*6 +: 6], 5'd8, 5'd11, imm16_t'($random(seed))));
         store(5'd11);
      end
      put(itype(op_lui, 5'd0, 5'd11, imm16_t'($random(seed))));
      store(5'd11);
      halt_syscall();
      run_program();
      start_program("loads");
      for (int i = 0; i < 8; i++) poke(i, $random(seed));
      for (int k = 0; k < 10; k++) begin
         put(itype(ld_ops[(k % 5)*6 +: 6], 5'd0, 5'd11, imm16_t'((k % 8) * 4)));
         store(5'd11);
      end
      halt_syscall();
      run_program();
      start_program("branch");
      x = $random(seed);
      load_const(5'd8, x);
      load_const(5'd9, x);
      load_const(5'd10, ~x);
      branch_case(itype(op_beq, 5'd8, 5'd9, 16'd2), 5'd8);    // taken
      branch_case(itype(op_beq, 5'd8, 5'd10, 16'd2), 5'd8);   // falls through
      branch_case(itype(op_bne, 5'd8, 5'd10, 16'd2), 5'd8);
      branch_case(itype(op_bne, 5'd8, 5'd9, 16'd2), 5'd8);
      branch_case(jtype(op_j, n + 3), 5'd8);
      branch_case(jtype(op_jal, n + 3), reg_ra);              // slot stores the link
      load_const(5'd12, text_start + (n + 5) * 4);
      branch_case(rtype(fn_jr, 5'd12, 5'd0, 5'd0, 5'd0), 5'd8);
      load_const(5'd12, text_start + (n + 5) * 4);
      branch_case(rtype(fn_jalr, 5'd12, 5'd0, 5'd13, 5'd0), 5'd13);
      halt_syscall();
      run_program();
      start_program("syscall");
      load_const(5'd8, $random(seed));
      put(itype(op_ori, 5'd0, reg_v0, 16'd5));
      put(rtype(fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));         // v0 = 5, keeps going
      store(5'd8);
      halt_syscall();
      store(5'd8);                                             // never reached
      run_program();
      start_program("reserved");
      load_const(5'd11, $random(seed));
      store(5'd11);
      put(itype(6'h3f, 5'd11, 5'd11, 16'h1234));              // undefined, rs and rt are $t3
      store(5'd11);
      run_program();
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+dv
rtl/mips_pkg.sv
rtl/pc_unit.sv
rtl/mips_decode.sv
rtl/regfile.sv
rtl/mips_alu.sv
rtl/load_unit.sv
rtl/mips_core.sv
dv/mips_core_assert.sv
dv/tb_mips_core.sv
